// File: src.f
+incdir+hdl
hdl/eth_stream_pkg.sv
hdl/adc_data_pkg.sv
hdl/rx_frame_decoder.sv
hdl/word_fifo.sv
hdl/packet_sender.sv
hdl/gmii_byte_serializer.sv
hdl/adc_stream_top.sv
bench/tb_adc_stream_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_adc_stream_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the model
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_adc_stream_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module tb_adc_stream_top import eth_stream_pkg::*, adc_data_pkg::*;
();

	localparam int PKT_BYTES   = `PKT_WORDS * `BYTES_PER_WORD;
	localparam int STIM_WORDS  = 2 * `PKT_WORDS + 2 * (`PKT_WORDS + 1) + 3 * `PKT_WORDS + 1 + 700;
	localparam int WATCHDOG_NS = STIM_WORDS * `BYTES_PER_WORD * 10 + 20000;
	localparam eth_flags_t SOF_F = eth_flags_t'(1 << `FLAG_SOF);
	localparam eth_flags_t EOF_F = eth_flags_t'(1 << `FLAG_EOF);

	logic       GMII_GTX_CLK_int;
	logic       rst_n_i;
	eth_word_t  rx_data;
	eth_flags_t rx_flags;
	logic       rx_valid;
	logic       rx_ready;
	adc_word_t  adc_data;
	logic       adc_we;
	gmii_byte_t gmii_txd;
	logic       gmii_tx_en;
	logic       adc_overflow;

	gmii_byte_t ref_q[$];      // Expected pin bytes, oldest first
	eth_word_t  body_q[$];     // Payload of the next frame
	gmii_byte_t exp_head = '0;
	logic       exp_have = 1'b0;
	logic       check_en;      // Byte compare on
	logic       ovf_allowed;
	logic       was_reset_q = 1'b0;
	int         low_run_q = 1000;   // Clocks with TX_EN low
	int         high_run_q = 0;     // Clocks with TX_EN high
	string      test_name;

	adc_stream_top u_adc_stream_top (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.rx_data_i        (rx_data),
		.rx_flags_i       (rx_flags),
		.rx_valid_i       (rx_valid),
		.rx_ready_o       (rx_ready),
		.adc_data_i       (adc_data),
		.adc_we_i         (adc_we),
		.gmii_txd_o       (gmii_txd),
		.gmii_tx_en_o     (gmii_tx_en),
		.adc_overflow_o   (adc_overflow)
	);

	initial
	begin
		GMII_GTX_CLK_int = 1'b0;
		forever #5 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// Reference bytes of one word, MSB first
	function automatic void expect_word(input eth_word_t w);
		int i;
		for (i = `BYTES_PER_WORD - 1; i >= 0; i--)
			ref_q.push_back(w[i*8 +: 8]);
	endfunction

	////////////////////
	// Monitor

	always @(posedge GMII_GTX_CLK_int)
	begin
		was_reset_q <= !rst_n_i;
		high_run_q  <= gmii_tx_en ? high_run_q + 1 : 0;
		if (gmii_tx_en)
			low_run_q <= 0;
		else if (low_run_q < 1000)
			low_run_q <= low_run_q + 1;   // Saturates
		if (rst_n_i && check_en && gmii_tx_en && (ref_q.size() > 0))
			void'(ref_q.pop_front());
	end

	// Queue head settles between edges
	always @(negedge GMII_GTX_CLK_int)
	begin
		exp_have = (ref_q.size() > 0);
		exp_head = exp_have ? ref_q[0] : '0;
	end

	a_reset_quiet: assert property (
		@(posedge GMII_GTX_CLK_int)
		was_reset_q |-> (!gmii_tx_en && !rx_ready && !adc_overflow)
	) else abort_run($sformatf("ERROR %s: tx_en,rx_ready,overflow expected 000 actual %b%b%b",
		test_name, $sampled(gmii_tx_en), $sampled(rx_ready), $sampled(adc_overflow)));

	a_byte_present: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		(check_en && gmii_tx_en) |-> exp_have
	) else abort_run($sformatf("In %s a GMII byte was sent when none was expected", test_name));

	a_byte_value: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		(check_en && gmii_tx_en && exp_have) |-> (gmii_txd == exp_head)
	) else abort_run($sformatf("ERROR %s: GMII byte expected %02h actual %02h",
		test_name, $sampled(exp_head), $sampled(gmii_txd)));

	a_gap_length: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		$rose(gmii_tx_en) |-> (low_run_q >= `IFG_CYCLES)
	) else abort_run($sformatf("ERROR %s: TX_EN low clocks expected >= %0d actual %0d",
		test_name, `IFG_CYCLES, $sampled(low_run_q)));

	a_packet_length: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		$fell(gmii_tx_en) |-> (high_run_q == PKT_BYTES)
	) else abort_run($sformatf("ERROR %s: packet bytes expected %0d actual %0d",
		test_name, PKT_BYTES, $sampled(high_run_q)));

	a_overflow_early: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		!ovf_allowed |-> !adc_overflow
	) else abort_run($sformatf("ERROR %s: adc_overflow_o expected 0 actual %b",
		test_name, $sampled(adc_overflow)));

	a_overflow_hold: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		adc_overflow |=> adc_overflow
	) else abort_run("adc_overflow_o fell without a reset");

	////////////////////
	// Drivers

	task automatic write_adc(input adc_word_t w, input int gap);
		adc_data = w;
		adc_we   = 1'b1;
		@(posedge GMII_GTX_CLK_int);
		#1;
		adc_we = 1'b0;
		repeat (gap - 1)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
		end
	endtask

	// Valid held until the edge that sees ready
	task automatic send_rx(input eth_word_t w, input eth_flags_t f);
		rx_data  = w;
		rx_flags = f;
		rx_valid = 1'b1;
		while (!rx_ready)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
		end
		@(posedge GMII_GTX_CLK_int);
		#1;
		rx_valid = 1'b0;
	endtask

	task automatic send_frame(input logic [15:0] tag);
		int k;
		send_rx({tag, 16'h0001}, SOF_F);
		for (k = 0; k < body_q.size(); k++)
			send_rx(body_q[k], (k == body_q.size() - 1) ? EOF_F : eth_flags_t'(0));
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (ref_q.size() != 0)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
			n++;
			if (n > limit)
				abort_run($sformatf("Timed out in %s with %0d bytes still expected",
					test_name, ref_q.size()));
		end
		repeat (20)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "watchdog");
	end

	////////////////////
	// Test sequence

	initial
	begin
		int          i;
		adc_word_t   w;
		eth_word_t   late_q[$];
		void'($urandom(93657));
		rst_n_i     = 1'b0;
		rx_data     = '0;
		rx_flags    = '0;
		rx_valid    = 1'b0;
		adc_data    = '0;
		adc_we      = 1'b0;
		check_en    = 1'b1;
		ovf_allowed = 1'b0;
		test_name   = "reset";
		repeat (2) @(posedge GMII_GTX_CLK_int);
		#1;
		rst_n_i = 1'b1;
		repeat (4) @(posedge GMII_GTX_CLK_int);
		#1;

		test_name = "adc_stream";   // Two packets, sparse writes
		for (i = 0; i < 2 * `PKT_WORDS; i++)
		begin
			w = $urandom;
			expect_word(w);
			write_adc(w, 4 + int'($urandom % 4));
		end
		wait_drain(4000);

		// Foreign header first, nothing of it may appear
		test_name = "cfg_filter";
		body_q.delete();
		for (i = 0; i < `PKT_WORDS; i++)
			body_q.push_back($urandom);
		send_frame(~`CFG_MAGIC);
		body_q.delete();
		for (i = 0; i < `PKT_WORDS; i++)
		begin
			body_q.push_back($urandom);
			expect_word(body_q[i]);
		end
		send_frame(`CFG_MAGIC);
		wait_drain(2000);

		test_name = "priority";
		for (i = 0; i < `PKT_WORDS; i++)
		begin
			w = $urandom;
			expect_word(w);
			write_adc(w, 1);
		end
		while (!gmii_tx_en)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
		end
		// Both queues fill while the first packet is on the pins
		body_q.delete();
		late_q.delete();
		for (i = 0; i < `PKT_WORDS; i++)
		begin
			body_q.push_back($urandom);
			late_q.push_back($urandom);
		end
		for (i = 0; i < `PKT_WORDS; i++)
			expect_word(body_q[i]);
		for (i = 0; i < `PKT_WORDS; i++)
			expect_word(late_q[i]);
		send_frame(`CFG_MAGIC);
		for (i = 0; i < `PKT_WORDS; i++)
			write_adc(late_q[i], 1);
		wait_drain(3000);

		test_name   = "overflow";
		check_en    = 1'b0;
		ovf_allowed = 1'b1;
		for (i = 0; i < 700; i++)
			write_adc($urandom, 1);
		repeat (2) @(posedge GMII_GTX_CLK_int);
		#1;
		a_overflow_set: assert (adc_overflow)
		else
			abort_run($sformatf("ERROR %s: adc_overflow_o expected 1 actual %b",
				test_name, adc_overflow));
		repeat (10) @(posedge GMII_GTX_CLK_int);
		#1;
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/adc_stream_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module adc_stream_top import eth_stream_pkg::*, adc_data_pkg::*;
(
	input  wire             GMII_GTX_CLK_int,
	input  wire             rst_n_i,

	// MAC receive stream
	input  wire eth_word_t  rx_data_i,
	input  wire eth_flags_t rx_flags_i,
	input  wire             rx_valid_i,
	output wire             rx_ready_o,

	// Assembled ADC words, no stall
	input  wire adc_word_t  adc_data_i,
	input  wire             adc_we_i,

	output wire gmii_byte_t gmii_txd_o,
	output wire             gmii_tx_en_o,
	output wire             adc_overflow_o
);

	wire eth_word_t  cfg_wr_data;
	wire eth_word_t  cfg_rd_data;
	wire eth_word_t  adc_rd_data;
	wire eth_word_t  tx_data;
	wire eth_flags_t tx_flags;
	wire             cfg_wr;
	wire             cfg_full;
	wire             cfg_rd;
	wire             cfg_avail;
	wire             adc_rd;
	wire             adc_avail;
	wire             tx_valid;
	wire             tx_ready;

	////////////////////
	// Decode

	rx_frame_decoder u_rx_frame_decoder (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.rx_data_i        (rx_data_i),
		.rx_flags_i       (rx_flags_i),
		.rx_valid_i       (rx_valid_i),
		.rx_ready_o       (rx_ready_o),
		.cfg_full_i       (cfg_full),
		.cfg_wr_o         (cfg_wr),
		.cfg_data_o       (cfg_wr_data)
	);

	////////////////////
	// Queues

	word_fifo #(.DEPTH(`CFG_FIFO_DEPTH)) u_cfg_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.wr_i             (cfg_wr),
		.wr_data_i        (cfg_wr_data),
		.rd_i             (cfg_rd),
		.rd_data_o        (cfg_rd_data),
		.full_o           (cfg_full),
		.empty_o          (),
		.pkt_avail_o      (cfg_avail),
		.overflow_o       ()          // Decoder never writes when full
	);

	word_fifo #(.DEPTH(`ADC_FIFO_DEPTH)) u_adc_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.wr_i             (adc_we_i),
		.wr_data_i        (adc_data_i),
		.rd_i             (adc_rd),
		.rd_data_o        (adc_rd_data),
		.full_o           (),
		.empty_o          (),
		.pkt_avail_o      (adc_avail),
		.overflow_o       (adc_overflow_o)
	);

	////////////////////
	// Execute and result

	packet_sender u_packet_sender (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.pri_data_i       (cfg_rd_data),
		.pri_avail_i      (cfg_avail),
		.pri_rd_o         (cfg_rd),
		.sec_data_i       (adc_rd_data),
		.sec_avail_i      (adc_avail),
		.sec_rd_o         (adc_rd),
		.tx_data_o        (tx_data),
		.tx_flags_o       (tx_flags),
		.tx_valid_o       (tx_valid),
		.tx_ready_i       (tx_ready)
	);

	gmii_byte_serializer u_gmii_byte_serializer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.tx_data_i        (tx_data),
		.tx_flags_i       (tx_flags),
		.tx_valid_i       (tx_valid),
		.tx_ready_o       (tx_ready),
		.gmii_txd_o       (gmii_txd_o),
		.gmii_tx_en_o     (gmii_tx_en_o)
	);

endmodule

`default_nettype wire

// File: hdl/gmii_byte_serializer.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module gmii_byte_serializer import eth_stream_pkg::*;
(
	input  wire             GMII_GTX_CLK_int,
	input  wire             rst_n_i,

	input  wire eth_word_t  tx_data_i,
	input  wire eth_flags_t tx_flags_i,
	input  wire             tx_valid_i,
	output logic            tx_ready_o,

	// Registered GMII pins
	output gmii_byte_t      gmii_txd_o,
	output logic            gmii_tx_en_o
);

	localparam int BW     = $clog2(`BYTES_PER_WORD);
	localparam int GW     = $clog2(`IFG_CYCLES);
	localparam int BYTE_W = $bits(gmii_byte_t);

	ser_state_t    state_q;
	eth_word_t     shift_q;       // Bytes still to go, MSB aligned
	logic [BW-1:0] byte_cnt_q;    // Byte currently on the pins
	logic [GW-1:0] gap_cnt_q;
	logic          eof_q;         // Word on the pins ends the packet
	logic          last_byte;
	logic          tx_xfer;

	assign last_byte = (byte_cnt_q == BW'(`BYTES_PER_WORD - 1));

	// Next word accepted during the fourth byte keeps bytes contiguous
	assign tx_ready_o = (state_q == SER_IDLE) ||
	                    ((state_q == SER_SHIFT) && last_byte && !eof_q);
	assign tx_xfer    = tx_valid_i & tx_ready_o;

	////////////////////
	// FSM and TX_EN

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			state_q      <= SER_IDLE;
			byte_cnt_q   <= '0;
			gap_cnt_q    <= '0;
			eof_q        <= 1'b0;
			gmii_tx_en_o <= 1'b0;
		end
		else if (tx_xfer)
		begin
			state_q      <= SER_SHIFT;
			byte_cnt_q   <= '0;
			eof_q        <= tx_flags_i[`FLAG_EOF];
			gmii_tx_en_o <= 1'b1;   // Alongside the first byte
		end
		else
		begin
			case (state_q)
				SER_SHIFT:
				begin
					if (!last_byte)
						byte_cnt_q <= byte_cnt_q + 1'b1;
					else
					begin
						gmii_tx_en_o <= 1'b0;
						gap_cnt_q    <= '0;
						state_q      <= eof_q ? SER_GAP : SER_IDLE;
					end
				end
				SER_GAP:
				begin
					gap_cnt_q <= gap_cnt_q + 1'b1;
					if (gap_cnt_q == GW'(`IFG_CYCLES - 1))
						state_q <= SER_IDLE;
				end
				default: ;
			endcase
		end
	end

	// Byte path, MSB first
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (tx_xfer)
		begin
			gmii_txd_o <= tx_data_i[`WORD_W-1 -: BYTE_W];
			shift_q    <= tx_data_i << BYTE_W;
		end
		else if ((state_q == SER_SHIFT) && !last_byte)
		begin
			gmii_txd_o <= shift_q[`WORD_W-1 -: BYTE_W];
			shift_q    <= shift_q << BYTE_W;
		end
	end

	// Every fall of TX_EN is a packet end
	a_ifg_held: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		$fell(gmii_tx_en_o) |-> !gmii_tx_en_o [*`IFG_CYCLES]
	);

endmodule

`default_nettype wire

// File: hdl/packet_sender.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module packet_sender import eth_stream_pkg::*, adc_data_pkg::*;
(
	input  wire             GMII_GTX_CLK_int,
	input  wire             rst_n_i,

	// Primary source, configuration queue
	input  wire eth_word_t  pri_data_i,
	input  wire             pri_avail_i,
	output logic            pri_rd_o,

	// Secondary source, ADC queue
	input  wire adc_word_t  sec_data_i,
	input  wire             sec_avail_i,
	output logic            sec_rd_o,

	// Word stream to the serializer
	output eth_word_t       tx_data_o,
	output eth_flags_t      tx_flags_o,
	output logic            tx_valid_o,
	input  wire             tx_ready_i
);

	localparam int CW = $clog2(`PKT_WORDS);

	logic          busy_q;       // Packet in progress
	logic          sel_pri_q;    // Source of the current packet
	logic [CW-1:0] word_cnt_q;   // Index of the word on offer
	logic          start;
	logic          tx_xfer;
	logic          first_word;
	logic          last_word;

	assign first_word = (word_cnt_q == '0);
	assign last_word  = (word_cnt_q == CW'(`PKT_WORDS - 1));

	// Boundary decision, primary wins
	assign start = ~busy_q & tx_ready_i & (pri_avail_i | sec_avail_i);

	assign tx_valid_o = busy_q;
	assign tx_xfer    = busy_q & tx_ready_i;

	// Head word is held by the FIFO until popped
	assign tx_data_o = sel_pri_q ? pri_data_i : eth_word_t'(sec_data_i);

	always_comb
	begin
		tx_flags_o = '0;
		tx_flags_o[`FLAG_SOF] = first_word;
		tx_flags_o[`FLAG_EOF] = last_word;
	end

	// Pop on every accepted transfer
	assign pri_rd_o = tx_xfer & sel_pri_q;
	assign sec_rd_o = tx_xfer & ~sel_pri_q;

	////////////////////
	// Packet control

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			busy_q     <= 1'b0;
			sel_pri_q  <= 1'b0;
			word_cnt_q <= '0;
		end
		else if (start)
		begin
			busy_q     <= 1'b1;
			sel_pri_q  <= pri_avail_i;
			word_cnt_q <= '0;
		end
		else if (tx_xfer)
		begin
			if (last_word)
			begin
				busy_q     <= 1'b0;   // EOF word gone
				word_cnt_q <= '0;
			end
			else
				word_cnt_q <= word_cnt_q + 1'b1;
		end
	end

	// Offered word holds while the serializer stalls
	a_word_held: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		(tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_data_o))
	);

endmodule

`default_nettype wire

// File: hdl/word_fifo.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module word_fifo import eth_stream_pkg::*, adc_data_pkg::*;
#(
	parameter int DEPTH = 256     // Power of two
)
(
	input  wire            GMII_GTX_CLK_int,
	input  wire            rst_n_i,

	input  wire            wr_i,
	input  wire eth_word_t wr_data_i,

	input  wire            rd_i,
	output eth_word_t      rd_data_o,    // Show-ahead head word

	output logic           full_o,
	output logic           empty_o,
	output logic           pkt_avail_o,  // At least one packet queued
	output logic           overflow_o    // Sticky until reset
);

	localparam int AW = $clog2(DEPTH);

	eth_word_t   mem_q [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	fifo_level_t level_q;
	logic        wr_en;
	logic        rd_en;

	assign full_o      = (level_q == fifo_level_t'(DEPTH));
	assign empty_o     = (level_q == '0);
	assign pkt_avail_o = (level_q >= fifo_level_t'(`PKT_WORDS));

	assign wr_en = wr_i & ~full_o;   // Dropped when full
	assign rd_en = rd_i & ~empty_o;

	assign rd_data_o = mem_q[rd_ptr_q];

	// Storage
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (wr_en)
			mem_q[wr_ptr_q] <= wr_data_i;
	end

	////////////////////
	// Pointers and level

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			level_q    <= '0;
			overflow_o <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at DEPTH
			if (rd_en)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10: level_q <= level_q + 1'b1;
				2'b01: level_q <= level_q - 1'b1;
				default: ;
			endcase
			if (wr_i && full_o)
				overflow_o <= 1'b1;
		end
	end

	// Reader sits in another module
	a_no_read_when_empty: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		rd_i |-> !empty_o
	);

endmodule

`default_nettype wire

// File: hdl/rx_frame_decoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "stream_consts.svh"

module rx_frame_decoder import eth_stream_pkg::*;
(
	input  wire             GMII_GTX_CLK_int,
	input  wire             rst_n_i,

	// Receive stream from the MAC
	input  wire eth_word_t  rx_data_i,
	input  wire eth_flags_t rx_flags_i,
	input  wire             rx_valid_i,
	output logic            rx_ready_o,

	// Configuration FIFO write side
	input  wire             cfg_full_i,
	output logic            cfg_wr_o,
	output eth_word_t       cfg_data_o
);

	logic run_q;           // Low in reset and on the first clock after it
	logic cfg_frame_q;     // Inside a matching frame, past its header
	logic rx_xfer;
	logic is_sof;
	logic is_eof;
	logic magic_hit;

	// Back-pressure straight from the FIFO
	assign rx_ready_o = run_q & ~cfg_full_i;
	assign rx_xfer    = rx_valid_i & rx_ready_o;

	assign is_sof    = rx_flags_i[`FLAG_SOF];
	assign is_eof    = rx_flags_i[`FLAG_EOF];
	assign magic_hit = (rx_data_i[`WORD_W-1:`WORD_W/2] == `CFG_MAGIC);

	// Header itself is never queued
	// Word lands in the FIFO on the accepting edge
	assign cfg_wr_o   = rx_xfer & cfg_frame_q & ~is_sof;
	assign cfg_data_o = rx_data_i;

	////////////////////
	// Frame position

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			run_q       <= 1'b0;
			cfg_frame_q <= 1'b0;
		end
		else
		begin
			run_q <= 1'b1;
			if (rx_xfer)
			begin
				if (is_sof)
					cfg_frame_q <= magic_hit & ~is_eof;   // Header-only frame carries nothing
				else if (is_eof)
					cfg_frame_q <= 1'b0;
			end
		end
	end

	// Stalled word stays on offer until taken
	a_rx_held: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		(rx_valid_i && !rx_ready_o) |=>
			(rx_valid_i && $stable(rx_data_i) && $stable(rx_flags_i))
	);

endmodule

`default_nettype wire

// File: hdl/adc_data_pkg.sv
`default_nettype none

`include "stream_consts.svh"

package adc_data_pkg;

	// One converter sample
	typedef logic [`WORD_W/2-1:0] adc_sample_t;

	// Sample pair, channel A upper half and channel B lower half
	typedef logic [`WORD_W-1:0] adc_word_t;

	// Queue occupancy, wide enough for 512 entries
	typedef logic [9:0] fifo_level_t;

endpackage

`default_nettype wire

// File: hdl/eth_stream_pkg.sv
`default_nettype none

`include "stream_consts.svh"

package eth_stream_pkg;

	////////////////////
	// Flagged word stream, 36 bits on the MAC side

	// Payload word
	typedef logic [`WORD_W-1:0] eth_word_t;

	// Flag field, bit 0 SOF and bit 1 EOF
	// Upper two bits unused, driven zero on transmit
	typedef logic [`FLAG_W-1:0] eth_flags_t;

	////////////////////
	// GMII side

	typedef logic [7:0] gmii_byte_t;   // One TXD byte

	// Serializer FSM
	typedef enum logic [1:0]
	{
		SER_IDLE  = 2'd0,   // Waiting for a word
		SER_SHIFT = 2'd1,   // Bytes of a word on the pins
		SER_GAP   = 2'd2    // Inter-packet gap
	} ser_state_t;

endpackage

`default_nettype wire

// File: hdl/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

////////////////////
// Word stream layout

`define WORD_W          32
`define FLAG_W          4
`define FLAG_SOF        0       // Start of frame bit
`define FLAG_EOF        1       // End of frame bit
`define BYTES_PER_WORD  4

////////////////////
// Packet framing

`define PKT_WORDS       128     // Words per transmitted packet
`define IFG_CYCLES      12      // Min clocks with TX_EN low between packets

// Header upper half that marks a configuration frame
`define CFG_MAGIC       16'hC0F1

////////////////////
// Queue sizes

`define ADC_FIFO_DEPTH  512
`define CFG_FIFO_DEPTH  256

`endif
